//--- hw/decoder_ctrl_pkg.sv
`default_nettype none

package decoder_ctrl_pkg;

    typedef enum logic [2:0] {
        STAGE_IDLE                  = 3'd0,
        STAGE_MEASUREMENT_LOADING   = 3'd1,
        STAGE_GROW                  = 3'd2,
        STAGE_MERGE                 = 3'd3,
        STAGE_PEELING               = 3'd4,
        STAGE_RESULT_VALID          = 3'd5,
        STAGE_PARAMETERS_LOADING    = 3'd6,
        STAGE_MEASUREMENT_PREPARING = 3'd7
    } stage_t;

    typedef logic [7:0]  byte_t;
    typedef logic [63:0] ctrl_msg_t;
    typedef logic [7:0]  opcode_t;
    typedef logic [7:0]  iteration_t;
    typedef logic [15:0] cycle_count_t;
    typedef logic [3:0]  round_count_t;

    localparam opcode_t OP_START_DECODING     = 8'h01;
    localparam opcode_t OP_MEASUREMENT_HEADER = 8'h02;
    localparam opcode_t OP_MOVE_TO_STAGE      = 8'h03;

    localparam int OPCODE_MSB = 47;

    // report word, iteration count sits where the opcode would be
    typedef struct packed {
        logic [63:OPCODE_MSB+1] reserved_hi;
        iteration_t             iterations;
        cycle_count_t           cycles;
        logic [23:0]            reserved_lo;
    } report_msg_t;

endpackage

`default_nettype wire

//--- hw/stage_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module stage_sequencer #(
    parameter int  GRID_WIDTH_X  = 4,
    parameter int  GRID_WIDTH_Z  = 1,
    parameter int  ROUNDS        = 3,
    parameter int  MAXIMUM_DELAY = 3,
    localparam int PU_COUNT      = GRID_WIDTH_X * GRID_WIDTH_Z * ROUNDS
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire decoder_ctrl_pkg::ctrl_msg_t ctrl_rx_data,
    input  wire                              ctrl_rx_valid,
    output logic                             ctrl_rx_ready,
    output logic                             in_ready,
    input  wire                              round_done,
    input  wire [PU_COUNT-1:0]               busy_pe,
    input  wire [PU_COUNT-1:0]               odd_clusters_pe,
    output decoder_ctrl_pkg::stage_t         stage
);

    localparam int DELAY_W = $clog2(MAXIMUM_DELAY + 2);
    localparam logic [DELAY_W-1:0] DELAY_DONE = DELAY_W'(MAXIMUM_DELAY);
    localparam decoder_ctrl_pkg::round_count_t LAST_ROUND =
        decoder_ctrl_pkg::round_count_t'(ROUNDS - 1);

    decoder_ctrl_pkg::opcode_t      opcode;
    decoder_ctrl_pkg::round_count_t round_cnt;
    logic [DELAY_W-1:0]             delay_cnt;
    logic                           busy_q;
    logic                           odd_q;

    assign opcode        = ctrl_rx_data[decoder_ctrl_pkg::OPCODE_MSB -: 8];
    assign ctrl_rx_ready = (stage == decoder_ctrl_pkg::STAGE_IDLE);
    assign in_ready      = (stage == decoder_ctrl_pkg::STAGE_MEASUREMENT_PREPARING);

    // one cycle behind the PEs
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            odd_q  <= 1'b0;
        end else begin
            busy_q <= |busy_pe;
            odd_q  <= |odd_clusters_pe;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage     <= decoder_ctrl_pkg::STAGE_IDLE;
            round_cnt <= '0;
            delay_cnt <= '0;
        end else begin
            case (stage)
                decoder_ctrl_pkg::STAGE_IDLE: begin
                    if (ctrl_rx_valid && ctrl_rx_ready) begin
                        case (opcode)
                            decoder_ctrl_pkg::OP_START_DECODING:
                                stage <= decoder_ctrl_pkg::STAGE_PARAMETERS_LOADING;
                            decoder_ctrl_pkg::OP_MEASUREMENT_HEADER: begin
                                stage     <= decoder_ctrl_pkg::STAGE_MEASUREMENT_PREPARING;
                                round_cnt <= '0;
                            end
                            decoder_ctrl_pkg::OP_MOVE_TO_STAGE:
                                stage <= decoder_ctrl_pkg::STAGE_GROW;
                            default: ;
                        endcase
                    end
                end
                decoder_ctrl_pkg::STAGE_PARAMETERS_LOADING: begin
                    stage     <= decoder_ctrl_pkg::STAGE_IDLE;
                    round_cnt <= '0;
                end
                decoder_ctrl_pkg::STAGE_MEASUREMENT_PREPARING: begin
                    if (round_done) begin
                        stage     <= decoder_ctrl_pkg::STAGE_MEASUREMENT_LOADING;
                        round_cnt <= round_cnt + 1'b1;
                    end
                end
                decoder_ctrl_pkg::STAGE_MEASUREMENT_LOADING: begin
                    if (round_cnt <= LAST_ROUND) begin // rounds still missing
                        stage <= decoder_ctrl_pkg::STAGE_MEASUREMENT_PREPARING;
                    end else begin
                        stage     <= decoder_ctrl_pkg::STAGE_GROW;
                        round_cnt <= '0;
                    end
                end
                decoder_ctrl_pkg::STAGE_GROW: begin
                    stage     <= decoder_ctrl_pkg::STAGE_MERGE;
                    delay_cnt <= '0;
                end
                decoder_ctrl_pkg::STAGE_MERGE: begin
                    if (delay_cnt < DELAY_DONE) begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end else if (!busy_q) begin
                        stage <= odd_q ? decoder_ctrl_pkg::STAGE_GROW
                                       : decoder_ctrl_pkg::STAGE_PEELING;
                    end
                end
                decoder_ctrl_pkg::STAGE_PEELING: stage <= decoder_ctrl_pkg::STAGE_RESULT_VALID;
                decoder_ctrl_pkg::STAGE_RESULT_VALID: begin
                    if (round_cnt == LAST_ROUND) begin
                        stage     <= decoder_ctrl_pkg::STAGE_IDLE;
                        round_cnt <= '0;
                    end else begin
                        round_cnt <= round_cnt + 1'b1;
                    end
                end
                default: stage <= decoder_ctrl_pkg::STAGE_IDLE;
            endcase
        end
    end

    a_stage_legal: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(stage) && stage inside {[decoder_ctrl_pkg::STAGE_IDLE :
                                              decoder_ctrl_pkg::STAGE_MEASUREMENT_PREPARING]});

    // no byte requested once every round is in
    a_in_ready_rounds: assert property (@(posedge clk) disable iff (reset)
        in_ready |-> round_cnt <= LAST_ROUND);

endmodule

`default_nettype wire

//--- hw/measurement_loader.sv
`timescale 1ns/1ps
`default_nettype none

module measurement_loader #(
    parameter int  GRID_WIDTH_X       = 4,
    parameter int  GRID_WIDTH_Z       = 1,
    localparam int PU_COUNT_PER_ROUND = GRID_WIDTH_X * GRID_WIDTH_Z,
    localparam int BYTES_PER_ROUND    = (PU_COUNT_PER_ROUND + 7) / 8,
    localparam int ALIGNED_WIDTH      = BYTES_PER_ROUND * 8
) (
    input  wire                            clk,
    input  wire                            reset,
    input  wire decoder_ctrl_pkg::stage_t  stage,
    input  wire decoder_ctrl_pkg::byte_t   in_data,
    input  wire                            in_valid,
    output logic [ALIGNED_WIDTH-1:0]       measurements,
    output logic                           round_done
);

    localparam int COUNT_W = $clog2(BYTES_PER_ROUND + 1);
    localparam logic [COUNT_W-1:0] LAST_BYTE = COUNT_W'(BYTES_PER_ROUND - 1);

    logic               accept;
    logic [COUNT_W-1:0] byte_cnt;

    assign accept     = in_valid && (stage == decoder_ctrl_pkg::STAGE_MEASUREMENT_PREPARING);
    assign round_done = accept && (byte_cnt == LAST_BYTE);

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_cnt <= '0;
        end else if (accept) begin
            byte_cnt <= round_done ? '0 : byte_cnt + 1'b1;
        end
    end

    // newest byte on top, older ones move toward bit 0
    always_ff @(posedge clk) begin
        if (accept) begin
            measurements <= ALIGNED_WIDTH'({in_data, measurements} >> 8);
        end
    end

endmodule

`default_nettype wire

//--- hw/decode_stats.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stats (
    input  wire                              clk,
    input  wire                              reset,
    input  wire decoder_ctrl_pkg::stage_t    stage,
    output decoder_ctrl_pkg::iteration_t     iterations,
    output decoder_ctrl_pkg::cycle_count_t   cycles,
    output logic                             report_valid,
    output decoder_ctrl_pkg::ctrl_msg_t      report_data
);

    decoder_ctrl_pkg::stage_t      stage_q;
    decoder_ctrl_pkg::report_msg_t report;
    logic                          grow_entry;
    logic                          job_start;

    assign grow_entry = (stage == decoder_ctrl_pkg::STAGE_GROW) &&
                        (stage_q != decoder_ctrl_pkg::STAGE_GROW);
    // fresh measurements or a move-to-stage message
    assign job_start  = grow_entry &&
                        (stage_q == decoder_ctrl_pkg::STAGE_MEASUREMENT_LOADING ||
                         stage_q == decoder_ctrl_pkg::STAGE_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_q    <= decoder_ctrl_pkg::STAGE_IDLE;
            iterations <= '0;
            cycles     <= '0;
        end else begin
            stage_q <= stage;
            if (stage == decoder_ctrl_pkg::STAGE_MEASUREMENT_LOADING) begin
                iterations <= '0;
            end else if (grow_entry) begin
                iterations <= iterations + 1'b1;
            end
            if (job_start) begin
                cycles <= 16'd2; // controller to PE propagation
            end else if (stage inside {decoder_ctrl_pkg::STAGE_GROW,
                                       decoder_ctrl_pkg::STAGE_MERGE,
                                       decoder_ctrl_pkg::STAGE_PEELING}) begin
                cycles <= cycles + 1'b1;
            end
        end
    end

    assign report_valid = (stage == decoder_ctrl_pkg::STAGE_RESULT_VALID) &&
                          (stage_q != decoder_ctrl_pkg::STAGE_RESULT_VALID);

    always_comb begin
        report            = '0;
        report.iterations = iterations;
        report.cycles     = cycles;
    end

    assign report_data = report;

endmodule

`default_nettype wire

//--- hw/correction_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module correction_serializer #(
    parameter int  GRID_WIDTH_X     = 4,
    parameter int  GRID_WIDTH_Z     = 1,
    parameter int  QUEUE_DEPTH      = 32,
    localparam int CORRECTION_WIDTH = 2 * (GRID_WIDTH_X - 1) * GRID_WIDTH_Z + 1 +
                                      GRID_WIDTH_X * GRID_WIDTH_Z
) (
    input  wire                            clk,
    input  wire                            reset,
    input  wire decoder_ctrl_pkg::stage_t  stage,
    input  wire [CORRECTION_WIDTH-1:0]     correction,
    output decoder_ctrl_pkg::byte_t        ser_data,
    output logic                           ser_valid,
    input  wire                            ser_ready
);

    localparam int BYTES_PER_WORD = (CORRECTION_WIDTH + 7) / 8;
    localparam int PADDED_WIDTH   = BYTES_PER_WORD * 8;
    localparam int PTR_W          = $clog2(QUEUE_DEPTH);
    localparam int COUNT_W        = $clog2(QUEUE_DEPTH + 1);
    localparam int IDX_W          = (BYTES_PER_WORD > 1) ? $clog2(BYTES_PER_WORD) : 1;
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(QUEUE_DEPTH - 1);
    localparam logic [IDX_W-1:0] LAST_BYTE = IDX_W'(BYTES_PER_WORD - 1);

    typedef logic [CORRECTION_WIDTH-1:0] word_t;
    typedef logic [PTR_W-1:0]            ptr_t;

    word_t                   mem [QUEUE_DEPTH];
    ptr_t                    wr_ptr;
    ptr_t                    rd_ptr;
    logic [COUNT_W-1:0]      count;
    logic [PADDED_WIDTH-1:0] word_q;
    logic [IDX_W-1:0]        byte_idx;
    logic                    result_q;
    logic                    full;
    logic                    push;
    logic                    pop;
    logic                    last_taken;

    assign full       = (count == COUNT_W'(QUEUE_DEPTH));
    assign push       = result_q && !full;
    assign last_taken = ser_valid && ser_ready && (byte_idx == LAST_BYTE);
    assign pop        = (count != '0) && (!ser_valid || last_taken);
    assign ser_data   = word_q[byte_idx*8 +: 8];

    // correction is valid the cycle after each result cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            result_q <= 1'b0;
        end else begin
            result_q <= (stage == decoder_ctrl_pkg::STAGE_RESULT_VALID);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + COUNT_W'(push) - COUNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= correction;
        end
        if (pop) begin
            word_q <= PADDED_WIDTH'(mem[rd_ptr]); // upper pad bits zero
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ser_valid <= 1'b0;
            byte_idx  <= '0;
        end else if (pop) begin
            ser_valid <= 1'b1;
            byte_idx  <= '0;
        end else if (last_taken) begin
            ser_valid <= 1'b0;
        end else if (ser_valid && ser_ready) begin
            byte_idx <= byte_idx + 1'b1;
        end
    end

    a_no_write_full: assert property (@(posedge clk) disable iff (reset)
        result_q |-> !full);

endmodule

`default_nettype wire

//--- hw/result_streamer.sv
`timescale 1ns/1ps
`default_nettype none

module result_streamer #(
    parameter int  GRID_WIDTH_X     = 4,
    parameter int  GRID_WIDTH_Z     = 1,
    parameter int  ROUNDS           = 3,
    localparam int CORRECTION_WIDTH = 2 * (GRID_WIDTH_X - 1) * GRID_WIDTH_Z + 1 +
                                      GRID_WIDTH_X * GRID_WIDTH_Z,
    localparam int BYTES_PER_WORD   = (CORRECTION_WIDTH + 7) / 8,
    localparam int STREAM_BYTES     = 3 + BYTES_PER_WORD * ROUNDS
) (
    input  wire                                clk,
    input  wire                                reset,
    input  wire decoder_ctrl_pkg::iteration_t  iterations,
    input  wire decoder_ctrl_pkg::cycle_count_t cycles,
    input  wire decoder_ctrl_pkg::byte_t       ser_data,
    input  wire                                ser_valid,
    output logic                               ser_ready,
    output decoder_ctrl_pkg::byte_t            out_data,
    output logic                               out_valid,
    input  wire                                out_ready
);

    localparam int POS_W = $clog2(STREAM_BYTES);
    localparam logic [POS_W-1:0] LAST_POS = POS_W'(STREAM_BYTES - 1);

    logic [POS_W-1:0] pos;

    always_ff @(posedge clk) begin
        if (reset) begin
            pos <= '0;
        end else if (ser_valid && out_ready) begin
            pos <= (pos == LAST_POS) ? '0 : pos + 1'b1;
        end
    end

    assign out_valid = ser_valid; // header waits for the first queued word

    always_comb begin
        out_data  = ser_data;
        ser_ready = out_ready;
        case (pos)
            POS_W'(0): begin
                out_data  = iterations;
                ser_ready = 1'b0;
            end
            POS_W'(1): begin
                out_data  = cycles[15:8];
                ser_ready = 1'b0;
            end
            POS_W'(2): begin
                out_data  = cycles[7:0];
                ser_ready = 1'b0;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/decoder_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module decoder_ctrl #(
    parameter int  GRID_WIDTH_X       = 4,
    parameter int  GRID_WIDTH_Z       = 1,
    parameter int  ROUNDS             = 3,
    parameter int  MAXIMUM_DELAY      = 3,
    parameter int  QUEUE_DEPTH        = 32,
    localparam int PU_COUNT_PER_ROUND = GRID_WIDTH_X * GRID_WIDTH_Z,
    localparam int ALIGNED_WIDTH      = ((PU_COUNT_PER_ROUND + 7) / 8) * 8,
    localparam int PU_COUNT           = PU_COUNT_PER_ROUND * ROUNDS,
    localparam int CORRECTION_WIDTH   = 2 * (GRID_WIDTH_X - 1) * GRID_WIDTH_Z + 1 +
                                        PU_COUNT_PER_ROUND
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire decoder_ctrl_pkg::ctrl_msg_t ctrl_rx_data,
    input  wire                              ctrl_rx_valid,
    output wire                              ctrl_rx_ready,
    input  wire decoder_ctrl_pkg::byte_t     in_data,
    input  wire                              in_valid,
    output wire                              in_ready,
    output wire decoder_ctrl_pkg::byte_t     out_data,
    output wire                              out_valid,
    input  wire                              out_ready,
    output wire                              report_valid,
    output wire decoder_ctrl_pkg::ctrl_msg_t report_data,
    input  wire [PU_COUNT-1:0]               busy_pe,
    input  wire [PU_COUNT-1:0]               odd_clusters_pe,
    output wire [ALIGNED_WIDTH-1:0]          measurements,
    input  wire [CORRECTION_WIDTH-1:0]       correction,
    output wire decoder_ctrl_pkg::stage_t    global_stage
);

    wire                                round_done;
    wire decoder_ctrl_pkg::iteration_t  iterations;
    wire decoder_ctrl_pkg::cycle_count_t cycles;
    wire decoder_ctrl_pkg::byte_t       ser_data;
    wire                                ser_valid;
    wire                                ser_ready;

    stage_sequencer #(
        .GRID_WIDTH_X (GRID_WIDTH_X),
        .GRID_WIDTH_Z (GRID_WIDTH_Z),
        .ROUNDS       (ROUNDS),
        .MAXIMUM_DELAY(MAXIMUM_DELAY)
    ) sequencer0 (
        .clk            (clk),
        .reset          (reset),
        .ctrl_rx_data   (ctrl_rx_data),
        .ctrl_rx_valid  (ctrl_rx_valid),
        .ctrl_rx_ready  (ctrl_rx_ready),
        .in_ready       (in_ready),
        .round_done     (round_done),
        .busy_pe        (busy_pe),
        .odd_clusters_pe(odd_clusters_pe),
        .stage          (global_stage)
    );

    measurement_loader #(
        .GRID_WIDTH_X(GRID_WIDTH_X),
        .GRID_WIDTH_Z(GRID_WIDTH_Z)
    ) loader0 (
        .clk         (clk),
        .reset       (reset),
        .stage       (global_stage),
        .in_data     (in_data),
        .in_valid    (in_valid),
        .measurements(measurements),
        .round_done  (round_done)
    );

    decode_stats stats0 (
        .clk         (clk),
        .reset       (reset),
        .stage       (global_stage),
        .iterations  (iterations),
        .cycles      (cycles),
        .report_valid(report_valid),
        .report_data (report_data)
    );

    correction_serializer #(
        .GRID_WIDTH_X(GRID_WIDTH_X),
        .GRID_WIDTH_Z(GRID_WIDTH_Z),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) serializer0 (
        .clk       (clk),
        .reset     (reset),
        .stage     (global_stage),
        .correction(correction),
        .ser_data  (ser_data),
        .ser_valid (ser_valid),
        .ser_ready (ser_ready)
    );

    result_streamer #(
        .GRID_WIDTH_X(GRID_WIDTH_X),
        .GRID_WIDTH_Z(GRID_WIDTH_Z),
        .ROUNDS      (ROUNDS)
    ) streamer0 (
        .clk       (clk),
        .reset     (reset),
        .iterations(iterations),
        .cycles    (cycles),
        .ser_data  (ser_data),
        .ser_valid (ser_valid),
        .ser_ready (ser_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

//--- tb/tb_decoder_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decoder_ctrl;

    localparam int ROUNDS        = 3;
    localparam int PU_COUNT      = 12;
    localparam int CORR_W        = 11;
    localparam int STREAM_BYTES  = 3 + 2 * ROUNDS;
    localparam int NUM_JOBS      = 4;
    localparam int TIMEOUT       = 1000;
    localparam logic [PU_COUNT-1:0] BUSY_PATTERN = 12'h801;
    localparam logic [PU_COUNT-1:0] ODD_PATTERN  = 12'h010;

    typedef struct packed {
        logic                                     move;  // job entered by move-to-stage
        decoder_ctrl_pkg::byte_t [0:ROUNDS-1]     meas;
        logic [3:0]                               k;     // odd merges before the even one
        logic [0:ROUNDS-1][CORR_W-1:0]            corr;
        logic [3:0]                               hold;  // busy cycles per merge
    } job_t;

    logic                           clk;
    logic                           reset;
    decoder_ctrl_pkg::ctrl_msg_t    ctrl_rx_data;
    logic                           ctrl_rx_valid;
    logic                           ctrl_rx_ready;
    decoder_ctrl_pkg::byte_t        in_data;
    logic                           in_valid;
    logic                           in_ready;
    decoder_ctrl_pkg::byte_t        out_data;
    logic                           out_valid;
    logic                           out_ready;
    logic                           report_valid;
    decoder_ctrl_pkg::ctrl_msg_t    report_data;
    logic [PU_COUNT-1:0]            busy_pe;
    logic [PU_COUNT-1:0]            odd_clusters_pe;
    logic [7:0]                     measurements;
    logic [CORR_W-1:0]              correction;
    decoder_ctrl_pkg::stage_t       global_stage;

    job_t jobs [NUM_JOBS];
    job_t cur_job;
    int   report_count;

    decoder_ctrl #(
        .GRID_WIDTH_X (4),
        .GRID_WIDTH_Z (1),
        .ROUNDS       (ROUNDS),
        .MAXIMUM_DELAY(3),
        .QUEUE_DEPTH  (32)
    ) dut0 (
        .clk            (clk),
        .reset          (reset),
        .ctrl_rx_data   (ctrl_rx_data),
        .ctrl_rx_valid  (ctrl_rx_valid),
        .ctrl_rx_ready  (ctrl_rx_ready),
        .in_data        (in_data),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .out_data       (out_data),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .report_valid   (report_valid),
        .report_data    (report_data),
        .busy_pe        (busy_pe),
        .odd_clusters_pe(odd_clusters_pe),
        .measurements   (measurements),
        .correction     (correction),
        .global_stage   (global_stage)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "stopping after the first error");
    endtask

    task automatic timed_out(input string what);
        $display("timeout at %0t: %s did not arrive within %0d cycles", $time, what, TIMEOUT);
        abort_run();
    endtask

    task automatic check_byte(input string name, input decoder_ctrl_pkg::byte_t got,
                              input decoder_ctrl_pkg::byte_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_iter(input string name, input decoder_ctrl_pkg::iteration_t got,
                              input decoder_ctrl_pkg::iteration_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cycles(input string name, input decoder_ctrl_pkg::cycle_count_t got,
                                input decoder_ctrl_pkg::cycle_count_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_stage(input string name, input decoder_ctrl_pkg::stage_t got,
                               input decoder_ctrl_pkg::stage_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %s, expected %s", $time, name, got.name(),
                     exp.name());
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // 8 bit fibonacci, taps 8 6 5 4
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic send_msg(input decoder_ctrl_pkg::opcode_t op);
        decoder_ctrl_pkg::ctrl_msg_t msg;
        int                          waited;
        msg    = '0;
        msg[decoder_ctrl_pkg::OPCODE_MSB -: 8] = op;
        waited = 0;
        @(negedge clk);
        while (!ctrl_rx_ready) begin
            waited++;
            if (waited > TIMEOUT) timed_out("ctrl_rx_ready");
            @(negedge clk);
        end
        @(posedge clk);
        ctrl_rx_valid <= 1'b1;
        ctrl_rx_data  <= msg;
        @(posedge clk);  // taken on this edge
        ctrl_rx_valid <= 1'b0;
    endtask

    // PE array model, follows the stage seen in the cycle just ending
    initial begin
        decoder_ctrl_pkg::stage_t stage_n;
        int                       grow_seen;
        int                       busy_left;
        int                       res_idx;
        busy_pe         = '0;
        odd_clusters_pe = '0;
        correction      = '0;
        grow_seen       = 0;
        busy_left       = 0;
        res_idx         = 0;
        forever begin
            @(negedge clk);
            stage_n = global_stage;
            @(posedge clk);
            case (stage_n)
                decoder_ctrl_pkg::STAGE_IDLE,
                decoder_ctrl_pkg::STAGE_MEASUREMENT_LOADING: grow_seen = 0;
                decoder_ctrl_pkg::STAGE_GROW: begin
                    odd_clusters_pe <= (grow_seen < int'(cur_job.k)) ? ODD_PATTERN : '0;
                    grow_seen = grow_seen + 1;
                    busy_left = int'(cur_job.hold);
                end
                default: ;
            endcase
            busy_pe <= (busy_left > 0) ? BUSY_PATTERN : '0;
            if (busy_left > 0) busy_left = busy_left - 1;
            if (stage_n == decoder_ctrl_pkg::STAGE_RESULT_VALID && res_idx < ROUNDS) begin
                correction <= cur_job.corr[res_idx]; // queued one cycle late
                res_idx = res_idx + 1;
            end else if (stage_n != decoder_ctrl_pkg::STAGE_RESULT_VALID) begin
                res_idx = 0;
            end
        end
    end

    initial begin
        report_count = 0;
        forever begin
            @(negedge clk);
            if (!reset && report_valid) report_count++;
        end
    end

    initial begin
        int                              waited;
        int                              got_n;
        int                              reports_before;
        decoder_ctrl_pkg::iteration_t    exp_iter;
        decoder_ctrl_pkg::byte_t         last_meas;
        decoder_ctrl_pkg::ctrl_msg_t     rep;
        decoder_ctrl_pkg::cycle_count_t  rep_cycles;
        decoder_ctrl_pkg::byte_t         stream [STREAM_BYTES];
        logic [7:0]                      lfsr;

        reset         = 1'b1;
        ctrl_rx_data  = '0;
        ctrl_rx_valid = 1'b0;
        in_data       = '0;
        in_valid      = 1'b0;
        out_ready     = 1'b0;
        cur_job       = '0;
        lfsr          = 8'd78;
        exp_iter      = '0;
        last_meas     = '0;

        jobs[0] = '{move: 1'b0, meas: {8'hA5, 8'h3C, 8'h0F}, k: 4'd0,
                    corr: {11'h7FF, 11'h123, 11'h4C6}, hold: 4'd0};
        jobs[1] = '{move: 1'b0, meas: {8'h81, 8'h7E, 8'h66}, k: 4'd2,
                    corr: {11'h0AA, 11'h555, 11'h700}, hold: 4'd5};
        jobs[2] = '{move: 1'b1, meas: {8'h00, 8'h00, 8'h00}, k: 4'd1,
                    corr: {11'h3FF, 11'h001, 11'h6B9}, hold: 4'd2};
        jobs[3] = '{move: 1'b0, meas: {8'hFF, 8'h11, 8'hC8}, k: 4'd3,
                    corr: {11'h246, 11'h13F, 11'h5A5}, hold: 4'd8};

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_stage("global_stage", global_stage, decoder_ctrl_pkg::STAGE_IDLE);
        check_bit("ctrl_rx_ready", ctrl_rx_ready, 1'b1);
        check_bit("in_ready", in_ready, 1'b0);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("report_valid", report_valid, 1'b0);

        for (int j = 0; j < NUM_JOBS; j++) begin
            cur_job        = jobs[j];
            reports_before = report_count;
            if (cur_job.move) begin
                send_msg(decoder_ctrl_pkg::OP_MOVE_TO_STAGE);
                @(negedge clk);
                check_stage("global_stage", global_stage, decoder_ctrl_pkg::STAGE_GROW);
                check_byte("measurements", measurements, last_meas); // not reloaded
                exp_iter = exp_iter + decoder_ctrl_pkg::iteration_t'(cur_job.k) + 8'd1;
            end else begin
                send_msg(decoder_ctrl_pkg::OP_START_DECODING);
                send_msg(decoder_ctrl_pkg::OP_MEASUREMENT_HEADER);
                for (int r = 0; r < ROUNDS; r++) begin
                    waited = 0;
                    @(negedge clk);
                    while (!in_ready) begin
                        waited++;
                        if (waited > TIMEOUT) timed_out("in_ready");
                        @(negedge clk);
                    end
                    @(posedge clk);
                    in_valid <= 1'b1;
                    in_data  <= cur_job.meas[r];
                    @(posedge clk);
                    in_valid <= 1'b0;
                    @(negedge clk);
                    check_stage("global_stage", global_stage,
                                decoder_ctrl_pkg::STAGE_MEASUREMENT_LOADING);
                    check_byte("measurements", measurements, cur_job.meas[r]);
                end
                @(negedge clk);
                check_stage("global_stage", global_stage, decoder_ctrl_pkg::STAGE_GROW);
                last_meas = cur_job.meas[ROUNDS-1];
                exp_iter  = decoder_ctrl_pkg::iteration_t'(cur_job.k) + 8'd1;
            end

            waited = 0;
            @(negedge clk);
            while (!report_valid) begin
                waited++;
                if (waited > TIMEOUT) timed_out("report_valid");
                @(negedge clk);
            end
            rep        = report_data;
            rep_cycles = rep[39:24];
            check_iter("report iterations", rep[47:40], exp_iter);
            if (rep_cycles < 16'd2) begin
                $display("report at %0t carries cycle count %0d, below 2", $time, rep_cycles);
                abort_run();
            end
            if (rep[63:48] != '0 || rep[23:0] != '0) begin
                $display("report at %0t has nonzero reserved bits: %h", $time, rep);
                abort_run();
            end

            // drain the stream with random stalls
            got_n  = 0;
            waited = 0;
            while (got_n < STREAM_BYTES) begin
                @(posedge clk);
                lfsr = lfsr_step(lfsr);
                out_ready <= lfsr[0];
                @(negedge clk);
                if (out_valid && out_ready) begin
                    stream[got_n] = out_data;
                    got_n++;
                end
                waited++;
                if (waited > TIMEOUT) timed_out("output stream byte");
            end
            @(posedge clk);
            out_ready <= 1'b0;
            @(negedge clk);
            check_bit("out_valid after last byte", out_valid, 1'b0);

            check_iter("stream iteration byte", stream[0], exp_iter);
            check_cycles("stream cycle header", {stream[1], stream[2]}, rep_cycles);
            for (int r = 0; r < ROUNDS; r++) begin
                check_byte($sformatf("correction %0d low byte", r), stream[3 + 2*r],
                           cur_job.corr[r][7:0]);
                check_byte($sformatf("correction %0d high byte", r), stream[4 + 2*r],
                           {5'b0, cur_job.corr[r][CORR_W-1:8]});
            end
            if (report_count - reports_before != 1) begin
                $display("job %0d raised report_valid %0d times instead of once", j,
                         report_count - reports_before);
                abort_run();
            end
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- decoder_ctrl.f
hw/decoder_ctrl_pkg.sv
hw/stage_sequencer.sv
hw/measurement_loader.sv
hw/decode_stats.sv
hw/correction_serializer.sv
hw/result_streamer.sv
hw/decoder_ctrl.sv
tb/tb_decoder_ctrl.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_decoder_ctrl \
    -f decoder_ctrl.f -o tb_decoder_ctrl > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_decoder_ctrl > sim.log 2>&1
cat sim.log
grep -q "^TESTS PASSED$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
